// File: verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

  //////////////////////////////////////////////////
  // Number format
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;
  localparam int ACC_WIDTH  = 40;

  //////////////////////////////////////////////////
  // Layer geometry
  localparam int IMAGE_WIDTH     = 8;
  localparam int IMAGE_HEIGHT    = 8;
  localparam int IMAGE_SIZE      = IMAGE_WIDTH * IMAGE_HEIGHT;
  localparam int CHANNEL_NUM_IN  = 2;
  localparam int CHANNEL_NUM_OUT = 2;
  localparam int KERNEL          = 3;
  localparam int KERNEL_TAPS     = KERNEL * KERNEL;
  // Dilation, distance between neighboring taps
  localparam int RATE            = 2;

  // Memory sizes
  localparam int FRAME_WORDS       = CHANNEL_NUM_IN * IMAGE_SIZE;
  localparam int WEIGHT_WORDS      = CHANNEL_NUM_OUT * CHANNEL_NUM_IN * KERNEL_TAPS;
  localparam int FRAME_ADDR_WIDTH  = $clog2(FRAME_WORDS);
  localparam int WEIGHT_ADDR_WIDTH = $clog2(WEIGHT_WORDS);
  localparam int PIXEL_ADDR_WIDTH  = $clog2(IMAGE_SIZE);

  // Counter widths of the replay loops
  localparam int CH_IN_WIDTH  = $clog2(CHANNEL_NUM_IN);
  localparam int CH_OUT_WIDTH = $clog2(CHANNEL_NUM_OUT);
  localparam int ROW_WIDTH    = $clog2(IMAGE_HEIGHT);
  localparam int COL_WIDTH    = $clog2(IMAGE_WIDTH);
  localparam int KIDX_WIDTH   = $clog2(KERNEL);

endpackage

`default_nettype wire

// File: verilog/conv_tap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tap_sequencer (
  input  wire logic                                     clk,
  input  wire logic                                     reset,
  input  wire logic                                     valid_in,
  input  wire logic [conv_pkg::DATA_WIDTH-1:0]          pxl_in,
  output logic                                          tap_valid,
  output logic      [conv_pkg::DATA_WIDTH-1:0]          tap_pxl,
  output logic      [conv_pkg::WEIGHT_ADDR_WIDTH-1:0]   tap_weight_addr,
  output logic                                          tap_last
);

  logic [conv_pkg::DATA_WIDTH-1:0]       frame_mem [conv_pkg::FRAME_WORDS];
  logic [conv_pkg::FRAME_ADDR_WIDTH-1:0] wr_ptr;
  logic                                  replaying;

  // Replay loop counters, oc outermost
  logic [conv_pkg::CH_OUT_WIDTH-1:0] oc;
  logic [conv_pkg::CH_IN_WIDTH-1:0]  ic;
  logic [conv_pkg::ROW_WIDTH-1:0]    y;
  logic [conv_pkg::COL_WIDTH-1:0]    x;
  logic [conv_pkg::KIDX_WIDTH-1:0]   ky;
  logic [conv_pkg::KIDX_WIDTH-1:0]   kx;

  logic oc_last, ic_last, y_last, x_last, ky_last, kx_last;

  int   ny, nx, faddr, waddr;
  logic inside_img;
  logic [conv_pkg::FRAME_ADDR_WIDTH-1:0] rd_addr;

  //////////////////////////////////////////////////
  // Frame loading
  always_ff @(posedge clk) begin
    if (valid_in && !replaying) begin
      frame_mem[wr_ptr] <= pxl_in;
    end
  end

  assign oc_last = int'(oc) == conv_pkg::CHANNEL_NUM_OUT - 1;
  assign ic_last = int'(ic) == conv_pkg::CHANNEL_NUM_IN - 1;
  assign y_last  = int'(y) == conv_pkg::IMAGE_HEIGHT - 1;
  assign x_last  = int'(x) == conv_pkg::IMAGE_WIDTH - 1;
  assign ky_last = int'(ky) == conv_pkg::KERNEL - 1;
  assign kx_last = int'(kx) == conv_pkg::KERNEL - 1;

  //////////////////////////////////////////////////
  // Load / replay control
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      replaying <= 1'b0;
      oc        <= '0;
      ic        <= '0;
      y         <= '0;
      x         <= '0;
      ky        <= '0;
      kx        <= '0;
    end else if (!replaying) begin
      if (valid_in) begin
        if (int'(wr_ptr) == conv_pkg::FRAME_WORDS - 1) begin
          wr_ptr    <= '0;
          replaying <= 1'b1;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end else begin
      kx <= kx_last ? '0 : kx + 1'b1;
      if (kx_last) begin
        ky <= ky_last ? '0 : ky + 1'b1;
        if (ky_last) begin
          x <= x_last ? '0 : x + 1'b1;
          if (x_last) begin
            y <= y_last ? '0 : y + 1'b1;
            if (y_last) begin
              ic <= ic_last ? '0 : ic + 1'b1;
              if (ic_last) begin
                oc <= oc_last ? '0 : oc + 1'b1;
                // Whole frame replayed for all output channels
                if (oc_last) begin
                  replaying <= 1'b0;
                end
              end
            end
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Dilated neighbor and border test
  always_comb begin
    ny = int'(y) + (int'(ky) - 1) * conv_pkg::RATE;
    nx = int'(x) + (int'(kx) - 1) * conv_pkg::RATE;
    inside_img = (ny >= 0) && (ny < conv_pkg::IMAGE_HEIGHT) &&
                 (nx >= 0) && (nx < conv_pkg::IMAGE_WIDTH);
    faddr = int'(ic) * conv_pkg::IMAGE_SIZE + ny * conv_pkg::IMAGE_WIDTH + nx;
    waddr = int'(oc) * conv_pkg::CHANNEL_NUM_IN * conv_pkg::KERNEL_TAPS
          + int'(ic) * conv_pkg::KERNEL_TAPS
          + int'(ky) * conv_pkg::KERNEL + int'(kx);
    // Out-of-image addresses are read but masked below
    rd_addr = faddr[conv_pkg::FRAME_ADDR_WIDTH-1:0];
  end

  assign tap_valid       = replaying;
  assign tap_pxl         = (replaying && inside_img) ? frame_mem[rd_addr] : '0;
  assign tap_weight_addr = waddr[conv_pkg::WEIGHT_ADDR_WIDTH-1:0];
  assign tap_last        = replaying && ky_last && kx_last;

endmodule

`default_nettype wire

// File: verilog/conv_weight_store.sv
`timescale 1ns/1ps
`default_nettype none

module conv_weight_store (
  input  wire logic                                   clk,
  input  wire logic                                   reset,
  input  wire logic                                   valid_weight_in,
  input  wire logic [conv_pkg::DATA_WIDTH-1:0]        weight_in,
  input  wire logic [conv_pkg::WEIGHT_ADDR_WIDTH-1:0] tap_weight_addr,
  output logic      [conv_pkg::DATA_WIDTH-1:0]        tap_weight
);

  logic [conv_pkg::DATA_WIDTH-1:0]        weight_mem [conv_pkg::WEIGHT_WORDS];
  logic [conv_pkg::WEIGHT_ADDR_WIDTH-1:0] wr_ptr;

  // Serial load, one weight per strobe
  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      weight_mem[wr_ptr] <= weight_in;
    end
  end

  // Pointer wraps so the next set lands on top of the old one
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (valid_weight_in) begin
      if (int'(wr_ptr) == conv_pkg::WEIGHT_WORDS - 1) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Same cycle as the tap
  assign tap_weight = weight_mem[tap_weight_addr];

endmodule

`default_nettype wire

// File: verilog/conv_tap_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tap_mac (
  input  wire logic                                   clk,
  input  wire logic                                   reset,
  input  wire logic                                   tap_valid,
  input  wire logic signed [conv_pkg::DATA_WIDTH-1:0] tap_pxl,
  input  wire logic signed [conv_pkg::DATA_WIDTH-1:0] tap_weight,
  input  wire logic                                   tap_last,
  output logic                                        part_valid,
  output logic signed      [conv_pkg::ACC_WIDTH-1:0]  part_sum
);

  logic signed [2*conv_pkg::DATA_WIDTH-1:0] prod;
  logic                                     prod_valid;
  logic                                     prod_last;
  logic signed [conv_pkg::ACC_WIDTH-1:0]    prod_ext;
  logic signed [conv_pkg::ACC_WIDTH-1:0]    acc;
  // High while the next product opens a new window
  logic                                     acc_first;

  //////////////////////////////////////////////////
  // Stage 1, product register
  always_ff @(posedge clk) begin
    prod <= tap_pxl * tap_weight;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
    end else begin
      prod_valid <= tap_valid;
      prod_last  <= tap_valid && tap_last;
    end
  end

  assign prod_ext = {{(conv_pkg::ACC_WIDTH - 2*conv_pkg::DATA_WIDTH){prod[2*conv_pkg::DATA_WIDTH-1]}},
                     prod};

  //////////////////////////////////////////////////
  // Stage 2, accumulate nine taps
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      if (acc_first) begin
        acc <= prod_ext;
      end else begin
        acc <= acc + prod_ext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_first  <= 1'b1;
      part_valid <= 1'b0;
    end else begin
      if (prod_valid) begin
        acc_first <= prod_last;
      end
      part_valid <= prod_valid && prod_last;
    end
  end

  assign part_sum = acc;

endmodule

`default_nettype wire

// File: verilog/conv_channel_adder.sv
`timescale 1ns/1ps
`default_nettype none

module conv_channel_adder (
  input  wire logic                                  clk,
  input  wire logic                                  reset,
  input  wire logic                                  part_valid,
  input  wire logic signed [conv_pkg::ACC_WIDTH-1:0] part_sum,
  output logic                                       res_valid,
  output logic signed      [conv_pkg::DATA_WIDTH-1:0] res_data
);

  logic signed [conv_pkg::ACC_WIDTH-1:0]  acc_mem [conv_pkg::IMAGE_SIZE];
  logic [conv_pkg::PIXEL_ADDR_WIDTH-1:0]  pix;
  logic [conv_pkg::CH_IN_WIDTH-1:0]       ch;
  logic                                   pix_last;
  logic                                   ch_last;

  logic signed [conv_pkg::ACC_WIDTH-1:0]  sum;
  logic signed [conv_pkg::ACC_WIDTH-1:0]  shifted;
  logic [conv_pkg::ACC_WIDTH-conv_pkg::DATA_WIDTH:0] top_bits;
  logic signed [conv_pkg::DATA_WIDTH-1:0] sat;

  assign pix_last = int'(pix) == conv_pkg::IMAGE_SIZE - 1;
  assign ch_last  = int'(ch) == conv_pkg::CHANNEL_NUM_IN - 1;

  //////////////////////////////////////////////////
  // Running sum, Q8.8 rescale and clamp
  always_comb begin
    if (ch == '0) begin
      sum = part_sum;
    end else begin
      sum = acc_mem[pix] + part_sum;
    end
    shifted  = sum >>> conv_pkg::FRAC_BITS;
    // Fits when everything above the sign bit copies it
    top_bits = shifted[conv_pkg::ACC_WIDTH-1:conv_pkg::DATA_WIDTH-1];
    if ((&top_bits) || !(|top_bits)) begin
      sat = shifted[conv_pkg::DATA_WIDTH-1:0];
    end else if (shifted[conv_pkg::ACC_WIDTH-1]) begin
      sat = {1'b1, {(conv_pkg::DATA_WIDTH-1){1'b0}}};
    end else begin
      sat = {1'b0, {(conv_pkg::DATA_WIDTH-1){1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    if (part_valid && !ch_last) begin
      acc_mem[pix] <= sum;
    end
    if (part_valid && ch_last) begin
      res_data <= sat;
    end
  end

  // Pixel counter inside, channel counter outside
  always_ff @(posedge clk) begin
    if (reset) begin
      pix       <= '0;
      ch        <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= part_valid && ch_last;
      if (part_valid) begin
        pix <= pix_last ? '0 : pix + 1'b1;
        if (pix_last) begin
          ch <= ch_last ? '0 : ch + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/conv_output_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module conv_output_fifo (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            res_valid,
  input  wire logic [conv_pkg::DATA_WIDTH-1:0] res_data,
  output logic      [conv_pkg::DATA_WIDTH-1:0] pxl_out,
  output logic                                 valid_out
);

  logic [conv_pkg::DATA_WIDTH-1:0]       fifo_mem [conv_pkg::IMAGE_SIZE];
  logic [conv_pkg::PIXEL_ADDR_WIDTH-1:0] wr_ptr;
  logic [conv_pkg::PIXEL_ADDR_WIDTH-1:0] rd_ptr;
  logic [conv_pkg::PIXEL_ADDR_WIDTH:0]   count;
  logic                                  full;
  logic                                  empty;
  logic                                  wr_en;
  logic                                  rd_en;
  logic                                  read_en;

  assign full  = int'(count) == conv_pkg::IMAGE_SIZE;
  assign empty = count == '0;
  assign wr_en = res_valid && !full;
  assign rd_en = read_en && !empty;

  //////////////////////////////////////////////////
  // Storage and registered read data
  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_mem[wr_ptr] <= res_data;
    end
    if (rd_en) begin
      pxl_out <= fifo_mem[rd_ptr];
    end
  end

  // Pointers wrap on the power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Start on first full, then keep streaming
  always_ff @(posedge clk) begin
    if (reset) begin
      read_en   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (full) begin
        read_en <= 1'b1;
      end
      valid_out <= rd_en;
    end
  end

endmodule

`default_nettype wire

// File: verilog/conv_dilated_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_dilated_top (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            valid_in,
  input  wire logic [conv_pkg::DATA_WIDTH-1:0] pxl_in,
  input  wire logic                            valid_weight_in,
  input  wire logic [conv_pkg::DATA_WIDTH-1:0] weight_in,
  output logic      [conv_pkg::DATA_WIDTH-1:0] pxl_out,
  output logic                                 valid_out
);

  // Tap stream
  logic                                   tap_valid;
  logic [conv_pkg::DATA_WIDTH-1:0]        tap_pxl;
  logic [conv_pkg::WEIGHT_ADDR_WIDTH-1:0] tap_weight_addr;
  logic                                   tap_last;
  logic [conv_pkg::DATA_WIDTH-1:0]        tap_weight;

  // Partial and final sums
  logic                                   part_valid;
  logic [conv_pkg::ACC_WIDTH-1:0]         part_sum;
  logic                                   res_valid;
  logic [conv_pkg::DATA_WIDTH-1:0]        res_data;

  //////////////////////////////////////////////////
  // Input side
  conv_tap_sequencer i_conv_tap_sequencer (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .tap_valid       (tap_valid),
    .tap_pxl         (tap_pxl),
    .tap_weight_addr (tap_weight_addr),
    .tap_last        (tap_last)
  );

  conv_weight_store i_conv_weight_store (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .tap_weight_addr (tap_weight_addr),
    .tap_weight      (tap_weight)
  );

  //////////////////////////////////////////////////
  // Processing
  conv_tap_mac i_conv_tap_mac (
    .clk        (clk),
    .reset      (reset),
    .tap_valid  (tap_valid),
    .tap_pxl    (tap_pxl),
    .tap_weight (tap_weight),
    .tap_last   (tap_last),
    .part_valid (part_valid),
    .part_sum   (part_sum)
  );

  conv_channel_adder i_conv_channel_adder (
    .clk        (clk),
    .reset      (reset),
    .part_valid (part_valid),
    .part_sum   (part_sum),
    .res_valid  (res_valid),
    .res_data   (res_data)
  );

  //////////////////////////////////////////////////
  // Output alignment
  conv_output_fifo i_conv_output_fifo (
    .clk       (clk),
    .reset     (reset),
    .res_valid (res_valid),
    .res_data  (res_data),
    .pxl_out   (pxl_out),
    .valid_out (valid_out)
  );

endmodule

`default_nettype wire

// File: verification/conv_dilated_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module conv_dilated_asserts (
  input wire logic clk,
  input wire logic reset,
  input wire logic tap_valid,
  input wire logic tap_last,
  input wire logic res_valid,
  input wire logic fifo_full,
  input wire logic valid_out
);

  int   tap_cnt;
  // Words written into the output FIFO minus words that came out
  int   words;
  logic streaming;
  int   failures = 0;

  // Position of the current tap inside its window
  always_ff @(posedge clk) begin
    if (reset) begin
      tap_cnt <= 0;
    end else if (tap_valid) begin
      tap_cnt <= (tap_cnt == conv_pkg::KERNEL_TAPS - 1) ? 0 : tap_cnt + 1;
    end
  end

  // A read shows on valid_out one cycle later, so the FIFO holds words - valid_out
  always_ff @(posedge clk) begin
    if (reset) begin
      words     <= 0;
      streaming <= 1'b0;
    end else begin
      words <= words + int'(res_valid) - int'(valid_out);
      if (valid_out) begin
        streaming <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output FIFO
  fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> !fifo_full)
    else begin
      $error("Result written into a full output FIFO");
      failures++;
    end

  fifo_no_underflow: assert property (@(posedge clk) disable iff (reset)
    words == int'(valid_out) |=> !valid_out)
    else begin
      $error("Output FIFO read while empty");
      failures++;
    end

  // Once output has begun, a FIFO with words in it is read every cycle
  read_en_sticky: assert property (@(posedge clk) disable iff (reset)
    streaming && words > int'(valid_out) |=> valid_out)
    else begin
      $error("FIFO read enable fell after it was set");
      failures++;
    end

  //////////////////////////////////////////////////
  // Tap stream
  tap_last_on_ninth: assert property (@(posedge clk) disable iff (reset)
    tap_last |-> tap_valid && tap_cnt == conv_pkg::KERNEL_TAPS - 1)
    else begin
      $error("tap_last not on the ninth tap of a window");
      failures++;
    end

  ninth_has_tap_last: assert property (@(posedge clk) disable iff (reset)
    tap_valid && tap_cnt == conv_pkg::KERNEL_TAPS - 1 |-> tap_last)
    else begin
      $error("Ninth tap of a window without tap_last");
      failures++;
    end

endmodule

bind conv_dilated_top conv_dilated_asserts i_conv_dilated_asserts (
  .clk        (clk),
  .reset      (reset),
  .tap_valid  (tap_valid),
  .tap_last   (tap_last),
  .res_valid  (res_valid),
  .fifo_full  (i_conv_output_fifo.full),
  .valid_out  (valid_out)
);

`default_nettype wire

// File: verification/conv_dilated_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_dilated_tb;

  localparam int CLK_PERIOD = 20;
  localparam int SEED       = 1;
  localparam int MAX_CYCLES = 16000;

  logic                            clk = 1'b0;
  logic                            reset;
  logic                            valid_in;
  logic [conv_pkg::DATA_WIDTH-1:0] pxl_in;
  logic                            valid_weight_in;
  logic [conv_pkg::DATA_WIDTH-1:0] weight_in;
  logic [conv_pkg::DATA_WIDTH-1:0] pxl_out;
  logic                            valid_out;

  // Current frame and weight set, as sent to the DUT
  logic signed [conv_pkg::DATA_WIDTH-1:0] frame   [conv_pkg::FRAME_WORDS];
  logic signed [conv_pkg::DATA_WIDTH-1:0] weights [conv_pkg::WEIGHT_WORDS];

  // Expected results in output order, rd_idx points at the next one
  logic [conv_pkg::DATA_WIDTH-1:0] exp_q [$];
  int   exp_cnt = 0;
  int   rd_idx = 0;
  int   res_count = 0;
  int   pending;
  int   cycles = 0;
  logic started = 1'b0;
  logic run_closed = 1'b0;

  conv_dilated_top i_conv_dilated_top (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string msg);
    run_closed = 1'b1;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  function automatic logic [conv_pkg::DATA_WIDTH-1:0] to_word(input int value);
    return value[conv_pkg::DATA_WIDTH-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Reference model of one output pixel
  function automatic logic [conv_pkg::DATA_WIDTH-1:0] expected_result(input int oc, input int y,
                                                                      input int x);
    longint sum;
    longint shifted;
    longint max_val;
    longint min_val;
    int     ny;
    int     nx;
    sum     = 0;
    max_val = (longint'(1) <<< (conv_pkg::DATA_WIDTH - 1)) - 1;
    min_val = -(longint'(1) <<< (conv_pkg::DATA_WIDTH - 1));
    for (int ic = 0; ic < conv_pkg::CHANNEL_NUM_IN; ic++) begin
      for (int ky = 0; ky < conv_pkg::KERNEL; ky++) begin
        for (int kx = 0; kx < conv_pkg::KERNEL; kx++) begin
          ny = y + (ky - 1) * conv_pkg::RATE;
          nx = x + (kx - 1) * conv_pkg::RATE;
          // Zero padding outside the image
          if (ny >= 0 && ny < conv_pkg::IMAGE_HEIGHT && nx >= 0 && nx < conv_pkg::IMAGE_WIDTH) begin
            sum += longint'(frame[ic * conv_pkg::IMAGE_SIZE + ny * conv_pkg::IMAGE_WIDTH + nx]) *
                   longint'(weights[(oc * conv_pkg::CHANNEL_NUM_IN + ic) * conv_pkg::KERNEL_TAPS
                                    + ky * conv_pkg::KERNEL + kx]);
          end
        end
      end
    end
    shifted = sum >>> conv_pkg::FRAC_BITS;
    if (shifted > max_val) shifted = max_val;
    if (shifted < min_val) shifted = min_val;
    return to_word(int'(shifted));
  endfunction

  task automatic random_pixels(input int mag);
    int v;
    for (int i = 0; i < conv_pkg::FRAME_WORDS; i++) begin
      v = int'($urandom_range(0, 2 * mag)) - mag;
      frame[i] = to_word(v);
    end
  endtask

  task automatic random_weights(input int mag);
    int v;
    for (int i = 0; i < conv_pkg::WEIGHT_WORDS; i++) begin
      v = int'($urandom_range(0, 2 * mag)) - mag;
      weights[i] = to_word(v);
    end
  endtask

  // A single 1.0 tap per (oc, ic), centered or at a random off-center spot
  task automatic single_tap_weights(input logic centered);
    int k;
    for (int blk = 0; blk < conv_pkg::CHANNEL_NUM_OUT * conv_pkg::CHANNEL_NUM_IN; blk++) begin
      k = conv_pkg::KERNEL_TAPS / 2;
      if (!centered) begin
        k = int'($urandom_range(0, conv_pkg::KERNEL_TAPS - 2));
        if (k >= conv_pkg::KERNEL_TAPS / 2) k = k + 1;
      end
      for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
        weights[blk * conv_pkg::KERNEL_TAPS + t] = (t == k) ? to_word(1 << conv_pkg::FRAC_BITS) : '0;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  task automatic send_frame();
    int gap;
    for (int i = 0; i < conv_pkg::FRAME_WORDS; i++) begin
      @(posedge clk);
      valid_in        <= 1'b1;
      pxl_in          <= frame[i];
      // Weights ride along with the first pixels
      valid_weight_in <= (i < conv_pkg::WEIGHT_WORDS);
      if (i < conv_pkg::WEIGHT_WORDS) begin
        weight_in <= weights[i];
      end
      gap = int'($urandom_range(0, 2));
      repeat (gap) begin
        @(posedge clk);
        valid_in        <= 1'b0;
        valid_weight_in <= 1'b0;
      end
    end
    @(posedge clk);
    valid_in        <= 1'b0;
    valid_weight_in <= 1'b0;
  endtask

  task automatic run_frame();
    for (int oc = 0; oc < conv_pkg::CHANNEL_NUM_OUT; oc++) begin
      for (int y = 0; y < conv_pkg::IMAGE_HEIGHT; y++) begin
        for (int x = 0; x < conv_pkg::IMAGE_WIDTH; x++) begin
          exp_q.push_back(expected_result(oc, y, x));
          exp_cnt++;
        end
      end
    end
    send_frame();
    while (rd_idx != exp_cnt) begin
      @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Output bookkeeping and watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!reset && valid_out) begin
      rd_idx  <= rd_idx + 1;
      started <= 1'b1;
    end
    if (!reset && i_conv_dilated_top.res_valid) begin
      res_count <= res_count + 1;
    end
    if (i_conv_dilated_top.i_conv_dilated_asserts.failures != 0) begin
      fail_run("A protocol assertion inside the DUT failed");
    end else if (cycles >= MAX_CYCLES) begin
      fail_run("Timeout, the DUT did not deliver all results in time");
    end
  end

  // Words still held by the FIFO
  assign pending = res_count - rd_idx - int'(valid_out);

  out_matches_model: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> pxl_out == exp_q[rd_idx])
    else fail_run($sformatf("[ERROR] %0t pxl_out %0d, expected %0d for result %0d", $time,
                            $signed($sampled(pxl_out)), $signed(exp_q[$sampled(rd_idx)]),
                            $sampled(rd_idx)));

  no_extra_output: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> rd_idx < exp_cnt)
    else fail_run("valid_out rose with no result left to deliver");

  low_in_reset: assert property (@(posedge clk) reset |=> !valid_out)
    else fail_run("valid_out was high during reset");

  waits_for_fill: assert property (@(posedge clk) disable iff (reset)
    valid_out && !started |-> res_count >= conv_pkg::IMAGE_SIZE)
    else fail_run("valid_out rose before the output FIFO had filled");

  streams_when_nonempty: assert property (@(posedge clk) disable iff (reset)
    started && pending > 0 |=> valid_out)
    else fail_run("valid_out stayed low although the FIFO held results");

  idle_when_empty: assert property (@(posedge clk) disable iff (reset)
    started && pending == 0 |=> !valid_out)
    else fail_run("valid_out rose although the FIFO was empty");

  initial begin
    void'($urandom(SEED));
    reset           <= 1'b1;
    valid_in        <= 1'b0;
    pxl_in          <= '0;
    valid_weight_in <= 1'b0;
    weight_in       <= '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);

    // Center taps only, the result is the channel sum
    random_pixels(4000);
    single_tap_weights(1'b1);
    run_frame();
    // One shifted tap per channel pair, checks dilation and padding
    random_pixels(4000);
    single_tap_weights(1'b0);
    run_frame();
    // Full range, mostly saturated at both limits
    random_pixels(32767);
    random_weights(32767);
    run_frame();
    // Small weights keep many sums in range, negative ones floor
    random_pixels(32767);
    random_weights(64);
    run_frame();

    // Quiet tail so a stray extra word still reaches no_extra_output
    repeat (20) @(posedge clk);
    run_closed = 1'b1;
    $display("NO ERRORS");
    $finish;
  end

  // Any other way the run can end counts as a failure
  final begin
    if (!run_closed) begin
      $display("ERRORS FOUND");
    end
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/conv_pkg.sv
verilog/conv_tap_sequencer.sv
verilog/conv_weight_store.sv
verilog/conv_tap_mac.sv
verilog/conv_channel_adder.sv
verilog/conv_output_fifo.sv
verilog/conv_dilated_top.sv
verification/conv_dilated_asserts.sv
verification/conv_dilated_tb.sv

// File: Makefile
# Verilator build and run of the dilated convolution testbench

VERILATOR ?= verilator
TOP       ?= conv_dilated_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
